/* design/srb_settings.svh */
/*
 * build-time constants for the settings and readback controller
 * include wherever FIFO depth, peripheral count or readback size is needed
 */

`ifndef SRB_SETTINGS_SVH
`define SRB_SETTINGS_SVH

// log2 of the entry count in each FIFO
`define SRB_FIFO_DEPTH_LOG2 2

// number of peripheral ready lines checked against the command mask
`define SRB_NUM_PERFS 4

// destination field placed in the reply protocol header
`define SRB_PROT_DEST 2'd0

// number of 32-bit readback words on the mux
`define SRB_NUM_READBACK 16

`endif

/* design/srb_pkg.sv */
/*
 * shared types for the settings and readback controller
 * referenced by scoped name from the design and the testbench
 */

package srb_pkg;

    // one 36-bit beat of the command or reply stream
    typedef struct packed {
        logic [1:0]  spare;
        logic        eof;
        logic        sop;
        logic [31:0] data;
    } stream_beat_t;

    // command header as seen by a poke
    typedef struct packed {
        logic [11:0] spare_hi;
        logic [3:0]  seq;
        logic [1:0]  spare_mid;
        logic [3:0]  mask;
        logic        spare_lo;
        logic        poke;
        logic [7:0]  addr;
    } cmd_hdr_poke_t;

    // command header as seen by the readback select
    typedef struct packed {
        logic [11:0] spare_hi;
        logic [3:0]  seq;
        logic [1:0]  spare_mid;
        logic [3:0]  mask;
        logic [5:0]  spare_lo;
        logic [3:0]  select;
    } cmd_hdr_peek_t;

    // same header word, decoded either way
    typedef union packed {
        cmd_hdr_poke_t poke;
        cmd_hdr_peek_t peek;
    } cmd_hdr_u;

    // command FIFO entry, 129 bits
    typedef struct packed {
        logic [63:0] ticks;
        cmd_hdr_u    hdr;
        logic [31:0] data;
        logic        has_time;
    } command_t;

    // result FIFO entry, 64 bits
    typedef struct packed {
        cmd_hdr_u    hdr;
        logic [31:0] data;
    } result_t;

endpackage

/* design/srb_fifo.sv */
/*
 * synchronous first-word-fall-through FIFO on a register array
 * read_data shows the head entry whenever empty is low
 */

`timescale 1ns/100ps

module srb_fifo #(
    parameter int WIDTH      = 32,
    parameter int DEPTH_LOG2 = 2
) (
    input  logic             clock,
    input  logic             reset,
    input  logic             write,
    input  logic [WIDTH-1:0] write_data,
    output logic             full,
    input  logic             read,
    output logic [WIDTH-1:0] read_data,
    output logic             empty
);

    localparam int DEPTH = 1 << DEPTH_LOG2;

    // storage has no reset, only the pointers and count do
    logic [WIDTH-1:0]      mem [DEPTH];
    logic [DEPTH_LOG2-1:0] wr_ptr;
    logic [DEPTH_LOG2-1:0] rd_ptr;
    logic [DEPTH_LOG2:0]   count;

    assign full      = (count == DEPTH[DEPTH_LOG2:0]);
    assign empty     = (count == '0);
    assign read_data = mem[rd_ptr];

    always_ff @(posedge clock) begin
        if (write) begin
            mem[wr_ptr] <= write_data;
        end
    end

    // pointers wrap naturally at the power-of-two depth
    always_ff @(posedge clock) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // simultaneous read and write leaves the count alone
            if (write && !read) begin
                count <= count + 1'b1;
            end else if (read && !write) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

/* design/srb_packet_parser.sv */
/*
 * walks each incoming command packet and writes one command FIFO entry
 * optional stream header fields are skipped, fractional time becomes the ticks
 */

`timescale 1ns/100ps

module srb_packet_parser (
    input  logic                  clock,
    input  logic                  reset,
    input  srb_pkg::stream_beat_t in_beat,
    input  logic                  in_valid,
    output logic                  in_ready,
    output logic                  cmd_write,
    output srb_pkg::command_t     cmd_word,
    input  logic                  cmd_full
);

    typedef enum logic [3:0] {
        PROT_HDR, STREAM_HDR, SID, CID0, CID1, TSI, TSF0, TSF1,
        CMD_HDR, CMD_DATA, WAIT_EOF, STORE
    } state_t;

    state_t            state;
    logic              take;
    logic              cid_reg;
    logic              tsi_reg;
    logic              tsf_reg;
    logic [63:0]       ticks_reg;
    srb_pkg::cmd_hdr_u hdr_reg;
    logic [31:0]       data_reg;

    // first optional field still to come, else the command header
    function automatic state_t next_field(input logic cid, input logic tsi, input logic tsf);
        state_t field;
        if (cid) field = CID0;
        else if (tsi) field = TSI;
        else if (tsf) field = TSF0;
        else field = CMD_HDR;
        return field;
    endfunction

    assign in_ready  = (state != STORE);
    assign take      = in_valid && in_ready;
    assign cmd_write = (state == STORE) && !cmd_full;

    // has_time follows the fractional time flag only
    assign cmd_word.ticks    = ticks_reg;
    assign cmd_word.hdr      = hdr_reg;
    assign cmd_word.data     = data_reg;
    assign cmd_word.has_time = tsf_reg;

    // ------------------------------------------------------------------------
    // packet walk
    // ------------------------------------------------------------------------
    always_ff @(posedge clock) begin
        if (reset) begin
            state <= PROT_HDR;
        end else begin
            case (state)
                // protocol header is taken as-is
                PROT_HDR: if (take) state <= STREAM_HDR;
                STREAM_HDR: begin
                    if (take) begin
                        if (in_beat.data[28]) state <= SID;
                        else state <= next_field(in_beat.data[27],
                                                 in_beat.data[23:22] != 2'b00,
                                                 in_beat.data[21:20] != 2'b00);
                    end
                end
                SID: if (take) state <= next_field(cid_reg, tsi_reg, tsf_reg);
                CID0: if (take) state <= CID1;
                CID1: if (take) state <= next_field(1'b0, tsi_reg, tsf_reg);
                TSI: if (take) state <= next_field(1'b0, 1'b0, tsf_reg);
                TSF0: if (take) state <= TSF1;
                TSF1: if (take) state <= CMD_HDR;
                CMD_HDR: if (take) state <= CMD_DATA;
                CMD_DATA: if (take) state <= in_beat.eof ? STORE : WAIT_EOF;
                // trailing beats up to eof are dropped
                WAIT_EOF: if (take && in_beat.eof) state <= STORE;
                STORE: if (!cmd_full) state <= PROT_HDR;
                default: state <= PROT_HDR;
            endcase
        end
    end

    // captured fields of the packet in flight
    always_ff @(posedge clock) begin
        if (take) begin
            case (state)
                STREAM_HDR: begin
                    cid_reg <= in_beat.data[27];
                    tsi_reg <= in_beat.data[23:22] != 2'b00;
                    tsf_reg <= in_beat.data[21:20] != 2'b00;
                end
                // upper half of the ticks first
                TSF0: ticks_reg[63:32] <= in_beat.data;
                TSF1: ticks_reg[31:0] <= in_beat.data;
                CMD_HDR: hdr_reg <= in_beat.data;
                CMD_DATA: data_reg <= in_beat.data;
                default: ;
            endcase
        end
    end

endmodule

/* design/srb_command_executor.sv */
/*
 * takes commands from the command FIFO one at a time and acts when allowed
 * pokes strobe the settings bus, every command samples one readback word
 */

`timescale 1ns/100ps
`include "srb_settings.svh"

module srb_command_executor (
    input  logic                          clock,
    input  logic                          reset,
    input  srb_pkg::command_t             cmd_word,
    input  logic                          cmd_empty,
    output logic                          cmd_read,
    output srb_pkg::result_t              res_word,
    input  logic                          res_full,
    output logic                          res_write,
    input  logic [63:0]                   vita_time,
    input  logic [`SRB_NUM_PERFS-1:0]     perfs_ready,
    input  logic [31:0]                   readback [`SRB_NUM_READBACK],
    output logic                          strobe,
    output logic [7:0]                    addr,
    output logic [31:0]                   data
);

    typedef enum logic {LOAD, EVENT} state_t;

    state_t                    state;
    srb_pkg::cmd_hdr_u         hdr_reg;
    logic [63:0]               ticks_reg;
    logic [31:0]               data_reg;
    logic                      has_time_reg;
    logic [31:0]               rb_data;
    logic [`SRB_NUM_PERFS-1:0] perfs_mask;
    logic                      perfs_ok;
    logic                      time_ok;
    logic                      action;

    // every masked peripheral must be ready
    assign perfs_mask = hdr_reg.poke.mask[`SRB_NUM_PERFS-1:0];
    assign perfs_ok   = (perfs_ready & perfs_mask) == perfs_mask;
    // untimed commands go at once, timed ones wait for the system time
    assign time_ok    = !has_time_reg || (vita_time >= ticks_reg);
    assign action     = (state == EVENT) && !res_full && perfs_ok && time_ok;

    // the pop and the result push happen together
    assign cmd_read      = action;
    assign res_write     = action;
    assign res_word.hdr  = hdr_reg;
    assign res_word.data = rb_data;

    assign addr = hdr_reg.poke.addr;
    assign data = data_reg;

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= LOAD;
        end else begin
            case (state)
                LOAD: if (!cmd_empty) state <= EVENT;
                EVENT: if (action) state <= LOAD;
                default: state <= LOAD;
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // head capture and readback sample, both in the load cycle
    // ------------------------------------------------------------------------
    always_ff @(posedge clock) begin
        if (state == LOAD && !cmd_empty) begin
            ticks_reg    <= cmd_word.ticks;
            hdr_reg      <= cmd_word.hdr;
            data_reg     <= cmd_word.data;
            has_time_reg <= cmd_word.has_time;
            rb_data      <= readback[cmd_word.hdr.peek.select];
        end
    end

    // one-cycle strobe the cycle after a poke acts
    always_ff @(posedge clock) begin
        if (reset) begin
            strobe <= 1'b0;
        end else begin
            strobe <= action && hdr_reg.poke.poke;
        end
    end

endmodule

/* design/srb_reply_framer.sv */
/*
 * turns each result FIFO entry into a four-beat reply packet
 * beats advance only on an output transfer, the entry pops on the last one
 */

`timescale 1ns/100ps
`include "srb_settings.svh"

module srb_reply_framer (
    input  logic                  clock,
    input  logic                  reset,
    input  srb_pkg::result_t      res_word,
    input  logic                  res_empty,
    output logic                  res_read,
    output srb_pkg::stream_beat_t out_beat,
    output logic                  out_valid,
    input  logic                  out_ready
);

    typedef enum logic [1:0] {PROT_HDR, STREAM_HDR, CMD_HDR, RB_DATA} state_t;

    state_t state;
    logic   sent;

    assign out_valid = !res_empty;
    assign sent      = out_valid && out_ready;
    assign res_read  = sent && (state == RB_DATA);

    // counter wraps from the data beat back to the protocol header
    always_ff @(posedge clock) begin
        if (reset) begin
            state <= PROT_HDR;
        end else if (sent) begin
            state <= state_t'(state + 2'd1);
        end
    end

    // ------------------------------------------------------------------------
    // beat contents, held while the sink stalls
    // ------------------------------------------------------------------------
    always_comb begin
        out_beat.spare = 2'b00;
        out_beat.sop   = (state == PROT_HDR);
        out_beat.eof   = (state == RB_DATA);
        case (state)
            // 12 bytes follow, framed, to the reply destination
            PROT_HDR: out_beat.data = {13'd0, `SRB_PROT_DEST, 1'b1, 16'd12};
            // stream header carries the sequence tag and a length of 3
            STREAM_HDR: out_beat.data = {12'h400, res_word.hdr.poke.seq, 16'd3};
            CMD_HDR: out_beat.data = res_word.hdr;
            default: out_beat.data = res_word.data;
        endcase
    end

endmodule

/* design/settings_readback_ctrl.sv */
/*
 * packet-driven settings bus and readback controller, top level
 * parser -> command FIFO -> executor -> result FIFO -> reply framer
 */

`timescale 1ns/100ps
`include "srb_settings.svh"

module settings_readback_ctrl (
    input  logic                      clock,
    input  logic                      reset,
    input  logic [63:0]               vita_time,
    input  logic [`SRB_NUM_PERFS-1:0] perfs_ready,
    input  srb_pkg::stream_beat_t     in_beat,
    input  logic                      in_valid,
    output logic                      in_ready,
    output srb_pkg::stream_beat_t     out_beat,
    output logic                      out_valid,
    input  logic                      out_ready,
    output logic                      strobe,
    output logic [7:0]                addr,
    output logic [31:0]               data,
    input  logic [31:0]               readback [`SRB_NUM_READBACK]
);

    // command path
    srb_pkg::command_t cmd_in;
    srb_pkg::command_t cmd_head;
    logic              cmd_write;
    logic              cmd_read;
    logic              cmd_full;
    logic              cmd_empty;

    // result path
    srb_pkg::result_t res_in;
    srb_pkg::result_t res_head;
    logic             res_write;
    logic             res_read;
    logic             res_full;
    logic             res_empty;

    srb_packet_parser parser (
        .clock, .reset, .in_beat, .in_valid, .in_ready,
        .cmd_write(cmd_write), .cmd_word(cmd_in), .cmd_full(cmd_full)
    );

    srb_fifo #(.WIDTH($bits(srb_pkg::command_t)), .DEPTH_LOG2(`SRB_FIFO_DEPTH_LOG2))
    command_fifo (
        .clock, .reset, .write(cmd_write), .write_data(cmd_in), .full(cmd_full),
        .read(cmd_read), .read_data(cmd_head), .empty(cmd_empty)
    );

    srb_command_executor executor (
        .clock, .reset,
        .cmd_word(cmd_head), .cmd_empty(cmd_empty), .cmd_read(cmd_read),
        .res_word(res_in), .res_full(res_full), .res_write(res_write),
        .vita_time, .perfs_ready, .readback, .strobe, .addr, .data
    );

    srb_fifo #(.WIDTH($bits(srb_pkg::result_t)), .DEPTH_LOG2(`SRB_FIFO_DEPTH_LOG2))
    result_fifo (
        .clock, .reset, .write(res_write), .write_data(res_in), .full(res_full),
        .read(res_read), .read_data(res_head), .empty(res_empty)
    );

    srb_reply_framer framer (
        .clock, .reset,
        .res_word(res_head), .res_empty(res_empty), .res_read(res_read),
        .out_beat, .out_valid, .out_ready
    );

endmodule

/* testbench/settings_readback_ctrl_assert.sv */
/*
 * handshake and strobe properties for the settings and readback controller
 * bound into settings_readback_ctrl from the testbench
 */

`timescale 1ns/100ps

module settings_readback_ctrl_assert (
    input logic                  clock,
    input logic                  reset,
    input srb_pkg::stream_beat_t out_beat,
    input logic                  out_valid,
    input logic                  out_ready,
    input logic                  strobe,
    input logic                  cmd_write,
    input logic                  cmd_full,
    input logic                  cmd_read,
    input logic                  cmd_empty,
    input logic                  res_write,
    input logic                  res_full,
    input logic                  res_read,
    input logic                  res_empty
);

    // a stalled reply beat must not move
    out_stable: assert property (@(posedge clock) disable iff (reset)
        out_valid && !out_ready |=> $stable(out_beat))
        else $error("reply beat changed while stalled");

    // settings strobe is a single-cycle pulse
    strobe_pulse: assert property (@(posedge clock) disable iff (reset)
        strobe |=> !strobe)
        else $error("strobe held for two cycles");

    // no push into a full FIFO, no pop from an empty one
    no_overflow: assert property (@(posedge clock) disable iff (reset)
        !(cmd_write && cmd_full) && !(res_write && res_full))
        else $error("FIFO written while full");

    no_underflow: assert property (@(posedge clock) disable iff (reset)
        !(cmd_read && cmd_empty) && !(res_read && res_empty))
        else $error("FIFO read while empty");

endmodule

/* testbench/settings_readback_ctrl_tb.sv */
/*
 * testbench for the settings and readback controller
 * sends command packets, predicts strobes and replies, compares them as they appear
 */

`timescale 1ns/100ps
`include "srb_settings.svh"

module settings_readback_ctrl_tb;

    localparam int WAIT_LIMIT = 500;

    logic                      clock = 1'b0;
    logic                      reset;
    logic [63:0]               vita_time;
    logic [`SRB_NUM_PERFS-1:0] perfs_ready;
    srb_pkg::stream_beat_t     in_beat;
    logic                      in_valid;
    logic                      in_ready;
    srb_pkg::stream_beat_t     out_beat;
    logic                      out_valid;
    logic                      out_ready;
    logic                      strobe;
    logic [7:0]                addr;
    logic [31:0]               data;
    logic [31:0]               readback [`SRB_NUM_READBACK];

    int          errors;
    int          strobes_seen;
    int          replies_seen;
    logic [63:0] strobe_time;
    logic [31:0] in_rng;
    logic [31:0] out_rng;

    // expected settings writes {addr, data} and reply beats, in order
    logic [39:0]           exp_strobes [$];
    srb_pkg::stream_beat_t exp_beats [$];

    settings_readback_ctrl dut (.*);

    bind settings_readback_ctrl settings_readback_ctrl_assert assertions (
        .clock, .reset, .out_beat, .out_valid, .out_ready, .strobe,
        .cmd_write, .cmd_full, .cmd_read, .cmd_empty,
        .res_write, .res_full, .res_read, .res_empty
    );

    always #5 clock = ~clock;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // seq 19:16, mask 13:10, poke 8, addr or select 7:0
    function automatic logic [31:0] cmd_header(input logic poke, input logic [7:0] addr_sel,
                                               input logic [3:0] mask, input logic [3:0] seq);
        return {12'h000, seq, 2'b00, mask, 1'b0, poke, addr_sel};
    endfunction

    // ------------------------------------------------------------------------
    // reference model of one reply beat
    // ------------------------------------------------------------------------
    function automatic srb_pkg::stream_beat_t reply_beat(input logic [31:0] hdr,
                                                         input logic [31:0] rb, input int idx);
        srb_pkg::stream_beat_t b;
        b.spare = 2'b00;
        b.sop   = (idx == 0);
        b.eof   = (idx == 3);
        case (idx)
            // length 12, frame bit, destination
            0: b.data = 32'd12 | (32'd1 << 16) | (32'(`SRB_PROT_DEST) << 17);
            1: b.data = {12'h400, hdr[19:16], 16'd3};
            2: b.data = hdr;
            default: b.data = rb;
        endcase
        return b;
    endfunction

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] expected);
        if (got !== expected) begin
            errors++;
            $display("[ERROR] %s: got %h, expected %h", name, got, expected);
        end
    endtask

    task automatic report_and_finish();
        $display("run finished, %0d error(s), %0d strobe(s), %0d reply packet(s)",
                 errors, strobes_seen, replies_seen);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    endtask

    task automatic give_up(input string what);
        errors++;
        $display("timeout while waiting for %s", what);
        report_and_finish();
    endtask

    // one beat, in_valid toggled at random until the parser takes it
    task automatic send_beat(input srb_pkg::stream_beat_t beat);
        int   cycles;
        logic accepted;
        cycles   = 0;
        accepted = 1'b0;
        while (!accepted) begin
            @(negedge clock);
            if (cycles == WAIT_LIMIT) begin
                give_up("the parser to accept a beat");
            end
            in_rng   = xorshift(in_rng);
            in_beat  = beat;
            in_valid = (in_rng[2:0] != 3'd0);
            // in_ready only changes on the rising edge
            accepted = in_valid && in_ready;
            cycles++;
        end
    endtask

    // opts: 0 stream id, 1 class id, 2 integer time, 3 trailing beats
    task automatic send_cmd(input logic [31:0] hdr, input logic [31:0] cmd_data,
                            input logic [3:0] opts, input logic timed, input logic [63:0] ticks);
        srb_pkg::stream_beat_t beats [$];
        logic [31:0]           shdr;
        int                    i;
        shdr = {3'b000, opts[0], opts[1], 3'b000, opts[2] ? 2'b01 : 2'b00,
                timed ? 2'b01 : 2'b00, 20'h00004};
        beats.push_back({4'b0001, 32'h0000_1000});
        beats.push_back({4'b0000, shdr});
        if (opts[0]) beats.push_back({4'b0000, 32'h5151_0001});
        if (opts[1]) begin
            beats.push_back({4'b0000, 32'hc1a5_0000});
            beats.push_back({4'b0000, 32'hc1a5_0001});
        end
        if (opts[2]) beats.push_back({4'b0000, 32'h0000_1234});
        if (timed) begin
            beats.push_back({4'b0000, ticks[63:32]});
            beats.push_back({4'b0000, ticks[31:0]});
        end
        beats.push_back({4'b0000, hdr});
        beats.push_back({4'b0000, cmd_data});
        if (opts[3]) begin
            beats.push_back({4'b0000, 32'h7777_0000});
            beats.push_back({4'b0000, 32'h7777_0001});
        end
        beats[beats.size() - 1].eof = 1'b1;
        // only pokes reach the settings bus
        if (hdr[8]) exp_strobes.push_back({hdr[7:0], cmd_data});
        for (i = 0; i < 4; i++) begin
            exp_beats.push_back(reply_beat(hdr, readback[hdr[3:0]], i));
        end
        foreach (beats[k]) begin
            send_beat(beats[k]);
        end
        @(negedge clock);
        in_valid = 1'b0;
    endtask

    task automatic wait_idle(input string what);
        int cycles;
        cycles = 0;
        while (exp_strobes.size() != 0 || exp_beats.size() != 0) begin
            @(negedge clock);
            if (cycles == WAIT_LIMIT) begin
                give_up(what);
            end
            cycles++;
        end
    endtask

    // ------------------------------------------------------------------------
    // monitor, compares strobes and reply beats against the queues
    // ------------------------------------------------------------------------
    always @(posedge clock) begin
        logic [39:0]           exp_s;
        srb_pkg::stream_beat_t exp_b;
        if (!reset && strobe) begin
            strobes_seen++;
            strobe_time = vita_time;
            if (exp_strobes.size() == 0) begin
                errors++;
                $display("a strobe came on the settings bus when none was expected");
            end else begin
                exp_s = exp_strobes.pop_front();
                check("addr", addr, exp_s[39:32]);
                check("data", data, exp_s[31:0]);
            end
        end
        if (!reset && out_valid && out_ready) begin
            if (out_beat.eof) replies_seen++;
            if (exp_beats.size() == 0) begin
                errors++;
                $display("a reply beat came out when none was expected");
            end else begin
                exp_b = exp_beats.pop_front();
                check("out_beat", out_beat, exp_b);
            end
        end
    end

    // sink readiness, own random stream
    always @(negedge clock) begin
        out_rng   = xorshift(out_rng);
        out_ready = (out_rng[1:0] != 2'd0);
    end

    initial begin
        int          before_s;
        int          before_r;
        int          cycles;
        logic [63:0] ticks;
        logic [31:0] hdr;
        reset        = 1'b1;
        vita_time    = 64'd1000;
        perfs_ready  = 4'hf;
        in_beat      = '0;
        in_valid     = 1'b0;
        out_ready    = 1'b0;
        errors       = 0;
        strobes_seen = 0;
        replies_seen = 0;
        strobe_time  = '0;
        in_rng       = 32'h6745_a28a;
        out_rng      = xorshift(~in_rng);
        // static readback words
        for (int i = 0; i < `SRB_NUM_READBACK; i++) begin
            in_rng      = xorshift(in_rng);
            readback[i] = in_rng;
        end
        repeat (2) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        // untimed poke, then a peek
        before_s = strobes_seen;
        send_cmd(cmd_header(1'b1, 8'h3c, 4'h0, 4'h1), 32'hdead_beef, 4'b0000, 1'b0, '0);
        wait_idle("the poke reply");
        check("poke strobe count", strobes_seen, before_s + 1);
        send_cmd(cmd_header(1'b0, 8'h07, 4'h0, 4'h2), 32'h0bad_f00d, 4'b0000, 1'b0, '0);
        wait_idle("the peek reply");
        check("peek strobe count", strobes_seen, before_s + 1);

        // every mix of optional beats gives the bare command
        for (int opts = 0; opts < 16; opts++) begin
            send_cmd(cmd_header(1'b1, 8'h5a, 4'h3, 4'h3), 32'h1357_9bdf, opts[3:0], 1'b0, '0);
            wait_idle("the reply of a packet with optional beats");
        end

        // ------------------------------------------------------------------------
        // timed poke held until vita_time reaches the ticks
        // ------------------------------------------------------------------------
        ticks    = 64'd1040;
        before_s = strobes_seen;
        send_cmd(cmd_header(1'b1, 8'h21, 4'h0, 4'h4), 32'h0000_00aa, 4'b0000, 1'b1, ticks);
        repeat (20) @(negedge clock);
        check("strobe count before time", strobes_seen, before_s);
        cycles = 0;
        while (strobes_seen == before_s) begin
            @(negedge clock);
            if (cycles == WAIT_LIMIT) begin
                give_up("the timed poke strobe");
            end
            vita_time = vita_time + 64'd1;
            cycles++;
        end
        // acts in the cycle vita_time equals the ticks, strobe shows one step later
        check("vita_time at strobe", strobe_time, ticks + 64'd1);
        wait_idle("the timed poke reply");

        // peripheral 2 not ready holds the command
        perfs_ready = 4'b1011;
        before_s    = strobes_seen;
        before_r    = replies_seen;
        send_cmd(cmd_header(1'b1, 8'h44, 4'b0100, 4'h5), 32'h4444_0000, 4'b0000, 1'b0, '0);
        repeat (20) @(negedge clock);
        check("strobe count while not ready", strobes_seen, before_s);
        check("reply count while not ready", replies_seen, before_r);
        perfs_ready = 4'hf;
        wait_idle("the masked command after readiness");
        check("strobe count after ready", strobes_seen, before_s + 1);

        // burst of eight under random out_ready
        before_r = replies_seen;
        for (int k = 0; k < 8; k++) begin
            in_rng = xorshift(in_rng);
            hdr    = cmd_header(in_rng[8], in_rng[7:0], in_rng[13:10], k[3:0]);
            in_rng = xorshift(in_rng);
            send_cmd(hdr, in_rng, 4'b0000, 1'b0, '0);
        end
        wait_idle("the burst replies");
        check("burst reply count", replies_seen, before_r + 8);

        report_and_finish();
    end

endmodule

/* filelist.f */
+incdir+design
design/srb_pkg.sv
design/srb_fifo.sv
design/srb_packet_parser.sv
design/srb_command_executor.sv
design/srb_reply_framer.sv
design/settings_readback_ctrl.sv
testbench/settings_readback_ctrl_assert.sv
testbench/settings_readback_ctrl_tb.sv
